// ==== Bender.yml ====
package:
  name: mvu

sources:
  - rtl/mvu_pkg.sv
  - rtl/mvu_bank_mem.sv
  - rtl/mvu_decode.sv
  - rtl/mvu_execute.sv
  - rtl/mvu_result.sv
  - rtl/mvu_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/mvu_tb.sv

// ==== bench/mvu_tb_ref.svh ====
/*
 * Testbench helpers for the matrix-vector unit:
 * job record type, reference model of the expected result,
 * compare tasks for the result word and single handshake bits
 */
`ifndef MVU_TB_REF_SVH
`define MVU_TB_REF_SVH

typedef struct packed {
    logic [PREC_W-1:0]       wp;
    logic [PREC_W-1:0]       ip;
    logic [BANK_ADDR_W-1:0]  wbase;
    logic [BANK_ADDR_W-1:0]  ibase;
    logic [LEN_W-1:0]        bc;
    mul_mode_e               mode;
    logic                    ws;
    logic                    ds;
    logic [SCALER_W-1:0]     scaler;
    logic [QMSB_W-1:0]       qmsb;
    logic [OPREC_W-1:0]      oprec;
} job_t;

// Rebuilds every element from the written planes and forms the dot product
function automatic logic [RESULT_W-1:0] expected_result(input job_t job);
    int                          wp;
    int                          ip;
    int                          wval;
    int                          dval;
    int                          lsb;
    longint                      acc;
    logic [BANK_ADDR_W-1:0]      addr;
    logic signed [SCALED_W-1:0]  scaled;
    logic [RESULT_W-1:0]         res;
    wp  = (job.mode == MUL_XNOR) ? 1 : int'(job.wp);
    ip  = (job.mode == MUL_XNOR) ? 1 : int'(job.ip);
    acc = 0;
    for (int b = 0; b < int'(job.bc); b++) begin
        for (int lane = 0; lane < N_LANES; lane++) begin
            wval = 0;
            dval = 0;
            for (int k = 0; k < wp; k++) begin
                addr = BANK_ADDR_W'(int'(job.wbase) + b * wp + k);  // Plane k of block b
                wval = wval + (int'(wmem_model[addr][lane]) << k);
            end
            for (int k = 0; k < ip; k++) begin
                addr = BANK_ADDR_W'(int'(job.ibase) + b * ip + k);
                dval = dval + (int'(dmem_model[addr][lane]) << k);
            end
            if (job.mode == MUL_XNOR) begin
                wval = 2 * wval - 1;  // Bit 1 is +1, bit 0 is -1
                dval = 2 * dval - 1;
            end else begin
                if (job.ws && wval >= (1 << (wp - 1))) wval = wval - (1 << wp);
                if (job.ds && dval >= (1 << (ip - 1))) dval = dval - (1 << ip);
            end
            acc = acc + longint'(wval) * longint'(dval);
        end
    end
    scaled = SCALED_W'(acc * longint'(signed'(job.scaler)));
    lsb    = int'(job.qmsb) + 1 - int'(job.oprec);  // Window ends at bit qmsb
    res    = '0;
    for (int i = 0; i < int'(job.oprec); i++) begin
        if (lsb + i < SCALED_W) res[i] = scaled[lsb + i];
    end
    return res;
endfunction

task automatic check_result(input logic [RESULT_W-1:0] expected,
                            input logic [RESULT_W-1:0] actual);
    if (actual !== expected) begin
        $display("Fail at %0d ns: result expected 0x%04h, got 0x%04h",
                 $time, expected, actual);
        value_errors++;
    end
endtask

task automatic check_ready(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("Fail at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
        value_errors++;
    end
endtask

`endif

// ==== bench/mvu_tb.sv ====
/*
 * Testbench for the matrix-vector unit:
 * clock and reset, plane memory preload, job stimulus,
 * random back-pressure on the result port,
 * comparison process against the reference model, cycle limit
 */
`timescale 1ns/100ps
`default_nettype none

module mvu_tb;
    import mvu_pkg::*;

    localparam int N_JOBS    = 24;
    localparam int READY_LEN = 1024;

    logic [N_LANES-1:0]    wmem_model [BANK_DEPTH];
    logic [N_LANES-1:0]    dmem_model [BANK_DEPTH];
    int                    value_errors;
    int                    protocol_errors;

    `include "mvu_tb_ref.svh"

    logic                    intf;
    logic                    rst_n;
    logic                    wmem_wr_en;
    logic [BANK_ADDR_W-1:0]  wmem_wr_addr;
    logic [N_LANES-1:0]      wmem_wr_word;
    logic                    dmem_wr_en;
    logic [BANK_ADDR_W-1:0]  dmem_wr_addr;
    logic [N_LANES-1:0]      dmem_wr_word;
    logic                    start_valid;
    logic                    start_ready;
    logic [PREC_W-1:0]       wprecision;
    logic [PREC_W-1:0]       iprecision;
    logic [BANK_ADDR_W-1:0]  wbaseaddr;
    logic [BANK_ADDR_W-1:0]  ibaseaddr;
    logic [LEN_W-1:0]        block_count;
    mul_mode_e               mul_mode;
    logic                    w_signed;
    logic                    d_signed;
    logic [SCALER_W-1:0]     scaler_b;
    logic [QMSB_W-1:0]       quant_msbidx;
    logic [OPREC_W-1:0]      oprecision;
    logic                    result_valid;
    logic                    result_ready;
    logic [RESULT_W-1:0]     result;

    job_t                    jobs [N_JOBS];
    logic [RESULT_W-1:0]     expected_q [$];
    logic                    ready_pattern [READY_LEN];
    int                      cycle_count;
    int                      cycle_limit;
    int                      in_flight;     // Jobs accepted and not yet taken from result
    logic                    held;
    logic [RESULT_W-1:0]     held_word;

    mvu_top i_dut (.*);

    always #10 intf = ~intf;

    // Kind 0 plain unsigned, 1 signed operands, 2 binary mode, 3 random scaler and window
    function automatic job_t make_job(input int kind, input int idx);
        job_t j;
        j.wp     = PREC_W'($urandom_range(1, MAX_PREC));
        j.ip     = PREC_W'($urandom_range(1, MAX_PREC));
        j.bc     = LEN_W'($urandom_range(1, 4));
        j.wbase  = BANK_ADDR_W'($urandom_range(0, 223));
        j.ibase  = BANK_ADDR_W'($urandom_range(0, 223));
        j.mode   = MUL_AND;
        j.ws     = 1'b0;
        j.ds     = 1'b0;
        j.scaler = SCALER_W'(1);
        j.oprec  = OPREC_W'(16);
        j.qmsb   = QMSB_W'(15);
        case (kind)
            1: begin
                j.ws = (idx % 3) != 1;  // Weights only, data only, then both
                j.ds = (idx % 3) != 0;
            end
            2: begin
                j.mode   = MUL_XNOR;
                j.scaler = SCALER_W'($urandom_range(1, 9));
            end
            3: begin
                j.mode   = mul_mode_e'($urandom_range(0, 1));
                j.ws     = 1'($urandom_range(0, 1));
                j.ds     = 1'($urandom_range(0, 1));
                j.scaler = SCALER_W'($urandom);
                j.oprec  = OPREC_W'($urandom_range(1, 16));
                j.qmsb   = QMSB_W'($urandom_range(int'(j.oprec) - 1, SCALED_W - 1));
            end
            default: ;
        endcase
        return j;
    endfunction

    // Cycle counter, result_ready pattern and the run limit
    always @(posedge intf) begin
        cycle_count++;
        result_ready <= ready_pattern[cycle_count % READY_LEN];
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Errors: %0d value mismatches, %0d missing or extra results",
                     value_errors, protocol_errors);
            $display("Testbench failed");
            $finish;
        end
    end

    // Compares each transferred result with the oldest pending job
    always @(posedge intf) begin
        if (rst_n) begin
            if (held) begin
                check_ready("result_valid", 1'b1, result_valid);
                check_result(held_word, result);  // Word must not change while held
            end
            // Two jobs in flight and a stalled result leave no room for a third
            if (in_flight >= 2 && !result_ready) check_ready("start_ready", 1'b0, start_ready);
            if (result_valid && result_ready) begin
                if (expected_q.size() == 0) begin
                    $display("Error at %0d ns: result arrived with no job pending", $time);
                    protocol_errors++;
                end else begin
                    check_result(expected_q.pop_front(), result);
                end
            end
            if (start_valid && start_ready) in_flight++;
            if (result_valid && result_ready) in_flight--;
            held      = result_valid && !result_ready;
            held_word = result;
        end
    end

    initial begin
        void'($urandom(32'hf492_1c60));
        intf            = 1'b0;
        rst_n           = 1'b0;
        wmem_wr_en      = 1'b0;
        wmem_wr_addr    = '0;
        wmem_wr_word    = '0;
        dmem_wr_en      = 1'b0;
        dmem_wr_addr    = '0;
        dmem_wr_word    = '0;
        start_valid     = 1'b0;
        wprecision      = '0;
        iprecision      = '0;
        wbaseaddr       = '0;
        ibaseaddr       = '0;
        block_count     = '0;
        mul_mode        = MUL_AND;
        w_signed        = 1'b0;
        d_signed        = 1'b0;
        scaler_b        = '0;
        quant_msbidx    = '0;
        oprecision      = '0;
        result_ready    = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        cycle_count     = 0;
        in_flight       = 0;
        held            = 1'b0;
        held_word       = '0;
        for (int a = 0; a < BANK_DEPTH; a++) begin
            wmem_model[a] = N_LANES'($urandom);
            dmem_model[a] = N_LANES'($urandom);
        end
        for (int i = 0; i < READY_LEN; i++) begin
            ready_pattern[i] = ($urandom_range(0, 99) < 60);
        end
        cycle_limit = 0;
        for (int j = 0; j < N_JOBS; j++) begin
            jobs[j] = make_job((j < 6) ? 0 : (j < 12) ? 1 : (j < 16) ? 2 : 3, j);
            cycle_limit += (jobs[j].mode == MUL_XNOR) ? int'(jobs[j].bc) + 20 :
                           int'(jobs[j].bc) * int'(jobs[j].wp) * int'(jobs[j].ip) + 20;
        end
        cycle_limit = 2 * cycle_limit + BANK_DEPTH + 10;  // Preload and reset on top

        repeat (2) @(posedge intf);
        rst_n <= 1'b1;
        @(posedge intf);
        check_ready("result_valid", 1'b0, result_valid);
        check_ready("start_ready", 1'b1, start_ready);

        for (int a = 0; a < BANK_DEPTH; a++) begin
            wmem_wr_en   <= 1'b1;
            wmem_wr_addr <= BANK_ADDR_W'(a);
            wmem_wr_word <= wmem_model[a];
            dmem_wr_en   <= 1'b1;
            dmem_wr_addr <= BANK_ADDR_W'(a);
            dmem_wr_word <= dmem_model[a];
            @(posedge intf);
        end
        wmem_wr_en <= 1'b0;
        dmem_wr_en <= 1'b0;

        for (int j = 0; j < N_JOBS; j++) begin
            start_valid  <= 1'b1;
            wprecision   <= jobs[j].wp;
            iprecision   <= jobs[j].ip;
            wbaseaddr    <= jobs[j].wbase;
            ibaseaddr    <= jobs[j].ibase;
            block_count  <= jobs[j].bc;
            mul_mode     <= jobs[j].mode;
            w_signed     <= jobs[j].ws;
            d_signed     <= jobs[j].ds;
            scaler_b     <= jobs[j].scaler;
            quant_msbidx <= jobs[j].qmsb;
            oprecision   <= jobs[j].oprec;
            do @(posedge intf); while (!start_ready);
            expected_q.push_back(expected_result(jobs[j]));  // Accepted on this edge
        end
        start_valid <= 1'b0;

        while (expected_q.size() != 0) @(posedge intf);
        repeat (2) @(posedge intf);
        $display("Errors: %0d value mismatches, %0d missing or extra results",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+bench
rtl/mvu_pkg.sv
rtl/mvu_bank_mem.sv
rtl/mvu_decode.sv
rtl/mvu_execute.sv
rtl/mvu_result.sv
rtl/mvu_top.sv
bench/mvu_tb.sv

// ==== rtl/mvu_bank_mem.sv ====
/*
 * Bit-plane memory, one lane bit per element of a word,
 * single write port and registered read port
 */
`timescale 1ns/100ps
`default_nettype none

module mvu_bank_mem (
    input  logic                              intf,
    input  logic                              wr_en,
    input  logic [mvu_pkg::BANK_ADDR_W-1:0]   wr_addr,
    input  logic [mvu_pkg::N_LANES-1:0]       wr_word,
    input  logic                              rd_en,
    input  logic [mvu_pkg::BANK_ADDR_W-1:0]   rd_addr,
    output logic [mvu_pkg::N_LANES-1:0]       rd_word
);
    import mvu_pkg::*;

    logic [N_LANES-1:0] mem [BANK_DEPTH];

    always_ff @(posedge intf) begin
        if (wr_en) mem[wr_addr] <= wr_word;
        if (rd_en) rd_word <= mem[rd_addr];  // Holds the last word between reads
    end

endmodule

`default_nettype wire

// ==== rtl/mvu_decode.sv ====
/*
 * Job controller and plane address generation:
 * start handshake and configuration capture, decode FSM,
 * block / weight bit / input bit sweep, MSB and last flags,
 * second copy of the result settings for the job in flight
 */
`timescale 1ns/100ps
`default_nettype none

module mvu_decode (
    input  logic                              intf,
    input  logic                              rst_n,
    input  logic                              start_valid,
    output logic                              start_ready,
    input  logic [mvu_pkg::PREC_W-1:0]        cfg_wprecision,
    input  logic [mvu_pkg::PREC_W-1:0]        cfg_iprecision,
    input  logic [mvu_pkg::BANK_ADDR_W-1:0]   cfg_wbaseaddr,
    input  logic [mvu_pkg::BANK_ADDR_W-1:0]   cfg_ibaseaddr,
    input  logic [mvu_pkg::LEN_W-1:0]         cfg_block_count,
    input  mvu_pkg::mul_mode_e                cfg_mul_mode,
    input  logic                              cfg_w_signed,
    input  logic                              cfg_d_signed,
    input  logic [mvu_pkg::SCALER_W-1:0]      cfg_scaler_b,
    input  logic [mvu_pkg::QMSB_W-1:0]        cfg_quant_msbidx,
    input  logic [mvu_pkg::OPREC_W-1:0]       cfg_oprecision,
    input  logic                              exec_hold,
    output logic                              rd_en,
    output logic [mvu_pkg::BANK_ADDR_W-1:0]   waddr,
    output logic [mvu_pkg::BANK_ADDR_W-1:0]   daddr,
    output logic                              w_msb,
    output logic                              d_msb,
    output logic                              ibit_last,
    output logic                              wbit_last,
    output logic                              job_last,
    output mvu_pkg::mul_mode_e                mul_mode,
    output logic                              w_signed,
    output logic                              d_signed,
    output logic [mvu_pkg::SCALER_W-1:0]      job_scaler_b,
    output logic [mvu_pkg::QMSB_W-1:0]        job_quant_msbidx,
    output logic [mvu_pkg::OPREC_W-1:0]       job_oprecision
);
    import mvu_pkg::*;

    decode_state_e           state_q;
    logic [PREC_W-1:0]       wprec_eff;
    logic [PREC_W-1:0]       iprec_eff;
    logic [PREC_W-1:0]       wprec_q;
    logic [PREC_W-1:0]       iprec_q;
    logic [BIT_W-1:0]        wtop;
    logic [BIT_W-1:0]        itop;
    logic [LEN_W-1:0]        blast_q;       // Index of the last block
    logic [LEN_W-1:0]        blk_q;
    logic [BIT_W-1:0]        wbit_q;
    logic [BIT_W-1:0]        ibit_q;
    logic [BANK_ADDR_W-1:0]  woff_q;        // Weight address of the current block
    logic [BANK_ADDR_W-1:0]  doff_q;        // Data address of the current block
    logic [SCALER_W-1:0]     scaler_q;
    logic [QMSB_W-1:0]       qmsb_q;
    logic [OPREC_W-1:0]      oprec_q;
    logic                    accept;

    // Binary mode sweeps a single plane pair per block
    assign wprec_eff = (cfg_mul_mode == MUL_XNOR) ? PREC_W'(1) : cfg_wprecision;
    assign iprec_eff = (cfg_mul_mode == MUL_XNOR) ? PREC_W'(1) : cfg_iprecision;
    assign wtop      = BIT_W'(wprec_q - 1'b1);
    assign itop      = BIT_W'(iprec_q - 1'b1);

    assign start_ready = (state_q == DEC_IDLE) && !exec_hold;
    assign accept      = start_valid && start_ready;
    assign rd_en       = (state_q == DEC_SWEEP);

    assign waddr     = woff_q + BANK_ADDR_W'(wbit_q);
    assign daddr     = doff_q + BANK_ADDR_W'(ibit_q);
    assign w_msb     = (wbit_q == wtop);
    assign d_msb     = (ibit_q == itop);
    assign ibit_last = (ibit_q == '0);
    assign wbit_last = ibit_last && (wbit_q == '0);
    assign job_last  = rd_en && wbit_last && (blk_q == blast_q);

    always_ff @(posedge intf) begin
        if (!rst_n) begin
            state_q <= DEC_IDLE;
        end else begin
            case (state_q)
                DEC_IDLE: begin
                    if (accept) state_q <= DEC_SWEEP;
                end
                DEC_SWEEP: begin
                    if (job_last) state_q <= exec_hold ? DEC_WAIT : DEC_IDLE;
                end
                DEC_WAIT: begin
                    if (!exec_hold) state_q <= DEC_IDLE;  // Sum of this job has moved on
                end
                default: state_q <= DEC_IDLE;
            endcase
        end
    end

    // Configuration capture and the three nested counters
    always_ff @(posedge intf) begin
        if (accept) begin
            wprec_q  <= wprec_eff;
            iprec_q  <= iprec_eff;
            blast_q  <= cfg_block_count - 1'b1;
            blk_q    <= '0;
            wbit_q   <= BIT_W'(wprec_eff - 1'b1);  // MSB first
            ibit_q   <= BIT_W'(iprec_eff - 1'b1);
            woff_q   <= cfg_wbaseaddr;
            doff_q   <= cfg_ibaseaddr;
            mul_mode <= cfg_mul_mode;
            w_signed <= cfg_w_signed && (cfg_mul_mode == MUL_AND);
            d_signed <= cfg_d_signed && (cfg_mul_mode == MUL_AND);
            scaler_q <= cfg_scaler_b;
            qmsb_q   <= cfg_quant_msbidx;
            oprec_q  <= cfg_oprecision;
        end else if (rd_en) begin
            if (ibit_last) begin
                ibit_q <= itop;
                if (wbit_q == '0) begin
                    wbit_q <= wtop;
                    blk_q  <= blk_q + 1'b1;
                    woff_q <= woff_q + BANK_ADDR_W'(wprec_q);
                    doff_q <= doff_q + BANK_ADDR_W'(iprec_q);
                end else begin
                    wbit_q <= wbit_q - 1'b1;
                end
            end else begin
                ibit_q <= ibit_q - 1'b1;
            end
        end
    end

    // Frees the first copy for the next job while result still needs these
    always_ff @(posedge intf) begin
        if (job_last) begin
            job_scaler_b     <= scaler_q;
            job_quant_msbidx <= qmsb_q;
            job_oprecision   <= oprec_q;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mvu_execute.sv ====
/*
 * Execute stage: weight and data plane memories,
 * flag alignment with the read data, AND / XNOR lane product,
 * MSB negation, shift accumulators and the finished sum register
 */
`timescale 1ns/100ps
`default_nettype none

module mvu_execute (
    input  logic                              intf,
    input  logic                              rst_n,
    input  logic                              wmem_wr_en,
    input  logic [mvu_pkg::BANK_ADDR_W-1:0]   wmem_wr_addr,
    input  logic [mvu_pkg::N_LANES-1:0]       wmem_wr_word,
    input  logic                              dmem_wr_en,
    input  logic [mvu_pkg::BANK_ADDR_W-1:0]   dmem_wr_addr,
    input  logic [mvu_pkg::N_LANES-1:0]       dmem_wr_word,
    input  logic                              rd_en,
    input  logic [mvu_pkg::BANK_ADDR_W-1:0]   waddr,
    input  logic [mvu_pkg::BANK_ADDR_W-1:0]   daddr,
    input  logic                              w_msb,
    input  logic                              d_msb,
    input  logic                              ibit_last,
    input  logic                              wbit_last,
    input  logic                              job_last,
    input  mvu_pkg::mul_mode_e                mul_mode,
    input  logic                              w_signed,
    input  logic                              d_signed,
    input  logic                              sum_ready,
    output logic                              sum_valid,
    output logic signed [mvu_pkg::ACC_W-1:0]  sum,
    output logic                              exec_hold
);
    import mvu_pkg::*;

    logic [N_LANES-1:0]       w_word;
    logic [N_LANES-1:0]       d_word;
    logic [N_LANES-1:0]       lane_bits;
    logic                     neg;
    logic [5:0]               flag_in;
    logic [5:0]               flag_pipe [MEM_RD_LATENCY];
    logic                     v_d;
    logic                     ilast_d;
    logic                     wlast_d;
    logic                     jlast_d;
    logic                     neg_d;
    logic                     xnor_d;
    logic signed [ACC_W-1:0]  pop;
    logic signed [ACC_W-1:0]  raw;
    logic signed [ACC_W-1:0]  partial;
    logic signed [ACC_W-1:0]  inner_q;
    logic signed [ACC_W-1:0]  wacc_q;
    logic signed [ACC_W-1:0]  jacc_q;
    logic signed [ACC_W-1:0]  inner_sum;
    logic signed [ACC_W-1:0]  w_sum;
    logic signed [ACC_W-1:0]  j_sum;

    mvu_bank_mem i_wmem (
        .intf    (intf),
        .wr_en   (wmem_wr_en),
        .wr_addr (wmem_wr_addr),
        .wr_word (wmem_wr_word),
        .rd_en   (rd_en),
        .rd_addr (waddr),
        .rd_word (w_word)
    );

    mvu_bank_mem i_dmem (
        .intf    (intf),
        .wr_en   (dmem_wr_en),
        .wr_addr (dmem_wr_addr),
        .wr_word (dmem_wr_word),
        .rd_en   (rd_en),
        .rd_addr (daddr),
        .rd_word (d_word)
    );

    // A signed MSB plane carries negative weight
    assign neg     = (w_signed && w_msb) ^ (d_signed && d_msb);
    assign flag_in = {rd_en, ibit_last, wbit_last, job_last, neg, mul_mode == MUL_XNOR};

    always_ff @(posedge intf) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_RD_LATENCY; i++) begin
                flag_pipe[i] <= '0;
            end
        end else begin
            flag_pipe[0] <= flag_in;
            for (int i = 1; i < MEM_RD_LATENCY; i++) begin
                flag_pipe[i] <= flag_pipe[i-1];
            end
        end
    end

    assign {v_d, ilast_d, wlast_d, jlast_d, neg_d, xnor_d} = flag_pipe[MEM_RD_LATENCY-1];

    assign lane_bits = xnor_d ? ~(w_word ^ d_word) : (w_word & d_word);

    always_comb begin
        pop = '0;
        for (int i = 0; i < N_LANES; i++) begin
            pop = pop + ACC_W'(lane_bits[i]);
        end
        raw     = xnor_d ? (pop <<< 1) - ACC_W'(N_LANES) : pop;  // Matches minus mismatches
        partial = neg_d ? -raw : raw;
    end

    // Each level doubles its running value and adds the level below
    assign inner_sum = (inner_q <<< 1) + partial;
    assign w_sum     = (wacc_q <<< 1) + inner_sum;
    assign j_sum     = jacc_q + w_sum;

    always_ff @(posedge intf) begin
        if (!rst_n) begin
            inner_q   <= '0;
            wacc_q    <= '0;
            jacc_q    <= '0;
            sum_valid <= 1'b0;
        end else begin
            if (v_d) begin
                inner_q <= ilast_d ? '0 : inner_sum;
                if (ilast_d) wacc_q <= wlast_d ? '0 : w_sum;
                if (wlast_d) jacc_q <= jlast_d ? '0 : j_sum;
            end
            if (v_d && jlast_d) begin
                sum_valid <= 1'b1;
            end else if (sum_ready) begin
                sum_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge intf) begin
        if (v_d && jlast_d) sum <= j_sum;
    end

    // Last plane still in flight, or finished sum not taken by result
    assign exec_hold = v_d || (sum_valid && !sum_ready);

endmodule

`default_nettype wire

// ==== rtl/mvu_pkg.sv ====
/*
 * Shared definitions for the matrix-vector unit:
 * lane count, memory and field widths, read latency,
 * multiply mode and decode FSM state enums
 */
`default_nettype none

package mvu_pkg;

    localparam int N_LANES        = 8;     // Vector elements per plane word
    localparam int BANK_ADDR_W    = 8;
    localparam int BANK_DEPTH     = 256;
    localparam int PREC_W         = 4;     // Holds precision 1 to 8
    localparam int MAX_PREC       = 8;
    localparam int BIT_W          = $clog2(MAX_PREC);  // Bit index within an operand
    localparam int LEN_W          = 6;     // Holds block count 1 to 63
    localparam int ACC_W          = 32;
    localparam int SCALER_W       = 16;
    localparam int SCALED_W       = 48;
    localparam int QMSB_W         = 6;
    localparam int OPREC_W        = 5;     // Holds output precision 1 to 16
    localparam int RESULT_W       = 16;
    localparam int MEM_RD_LATENCY = 1;

    typedef enum logic {
        MUL_AND,                           // Popcount of weight AND data
        MUL_XNOR                           // Binary +1/-1 product
    } mul_mode_e;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_SWEEP,
        DEC_WAIT
    } decode_state_e;

endpackage

`default_nettype wire

// ==== rtl/mvu_result.sv ====
/*
 * Result stage: scaler multiply, quantizer window
 * below the MSB index, output register with valid/ready
 */
`timescale 1ns/100ps
`default_nettype none

module mvu_result (
    input  logic                              intf,
    input  logic                              rst_n,
    input  logic                              sum_valid,
    output logic                              sum_ready,
    input  logic signed [mvu_pkg::ACC_W-1:0]  sum,
    input  logic [mvu_pkg::SCALER_W-1:0]      job_scaler_b,
    input  logic [mvu_pkg::QMSB_W-1:0]        job_quant_msbidx,
    input  logic [mvu_pkg::OPREC_W-1:0]       job_oprecision,
    output logic                              result_valid,
    input  logic                              result_ready,
    output logic [mvu_pkg::RESULT_W-1:0]      result
);
    import mvu_pkg::*;

    logic signed [SCALED_W-1:0]  scaled;
    logic [QMSB_W-1:0]           lsb_idx;
    logic [SCALED_W-1:0]         shifted;
    logic [RESULT_W-1:0]         mask;
    logic [RESULT_W-1:0]         quant;
    logic                        load;

    assign scaled  = sum * $signed(job_scaler_b);
    assign lsb_idx = job_quant_msbidx + QMSB_W'(1) - QMSB_W'(job_oprecision);
    assign shifted = scaled >> lsb_idx;
    assign mask    = ~({RESULT_W{1'b1}} << job_oprecision);  // Keeps oprecision low bits
    assign quant   = shifted[RESULT_W-1:0] & mask;

    assign sum_ready = !result_valid || result_ready;
    assign load      = sum_valid && sum_ready;

    always_ff @(posedge intf) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else if (load) begin
            result_valid <= 1'b1;
        end else if (result_ready) begin
            result_valid <= 1'b0;
        end
    end

    always_ff @(posedge intf) begin
        if (load) result <= quant;  // Held while result_ready is low
    end

endmodule

`default_nettype wire

// ==== rtl/mvu_top.sv ====
/*
 * Matrix-vector unit top level:
 * decode, execute and result stages and their wiring
 */
`timescale 1ns/100ps
`default_nettype none

module mvu_top (
    input  logic                              intf,
    input  logic                              rst_n,
    input  logic                              wmem_wr_en,
    input  logic [mvu_pkg::BANK_ADDR_W-1:0]   wmem_wr_addr,
    input  logic [mvu_pkg::N_LANES-1:0]       wmem_wr_word,
    input  logic                              dmem_wr_en,
    input  logic [mvu_pkg::BANK_ADDR_W-1:0]   dmem_wr_addr,
    input  logic [mvu_pkg::N_LANES-1:0]       dmem_wr_word,
    input  logic                              start_valid,
    output logic                              start_ready,
    input  logic [mvu_pkg::PREC_W-1:0]        wprecision,
    input  logic [mvu_pkg::PREC_W-1:0]        iprecision,
    input  logic [mvu_pkg::BANK_ADDR_W-1:0]   wbaseaddr,
    input  logic [mvu_pkg::BANK_ADDR_W-1:0]   ibaseaddr,
    input  logic [mvu_pkg::LEN_W-1:0]         block_count,
    input  mvu_pkg::mul_mode_e                mul_mode,
    input  logic                              w_signed,
    input  logic                              d_signed,
    input  logic [mvu_pkg::SCALER_W-1:0]      scaler_b,
    input  logic [mvu_pkg::QMSB_W-1:0]        quant_msbidx,
    input  logic [mvu_pkg::OPREC_W-1:0]       oprecision,
    output logic                              result_valid,
    input  logic                              result_ready,
    output logic [mvu_pkg::RESULT_W-1:0]      result
);
    import mvu_pkg::*;

    logic                     rd_en;
    logic [BANK_ADDR_W-1:0]   waddr;
    logic [BANK_ADDR_W-1:0]   daddr;
    logic                     w_msb;
    logic                     d_msb;
    logic                     ibit_last;
    logic                     wbit_last;
    logic                     job_last;
    mul_mode_e                rd_mul_mode;   // Job copy travelling with the read stream
    logic                     rd_w_signed;
    logic                     rd_d_signed;
    logic                     exec_hold;
    logic                     sum_valid;
    logic                     sum_ready;
    logic signed [ACC_W-1:0]  sum;
    logic [SCALER_W-1:0]      job_scaler_b;
    logic [QMSB_W-1:0]        job_quant_msbidx;
    logic [OPREC_W-1:0]       job_oprecision;

    mvu_decode i_decode (
        .intf             (intf),
        .rst_n            (rst_n),
        .start_valid      (start_valid),
        .start_ready      (start_ready),
        .cfg_wprecision   (wprecision),
        .cfg_iprecision   (iprecision),
        .cfg_wbaseaddr    (wbaseaddr),
        .cfg_ibaseaddr    (ibaseaddr),
        .cfg_block_count  (block_count),
        .cfg_mul_mode     (mul_mode),
        .cfg_w_signed     (w_signed),
        .cfg_d_signed     (d_signed),
        .cfg_scaler_b     (scaler_b),
        .cfg_quant_msbidx (quant_msbidx),
        .cfg_oprecision   (oprecision),
        .exec_hold        (exec_hold),
        .rd_en            (rd_en),
        .waddr            (waddr),
        .daddr            (daddr),
        .w_msb            (w_msb),
        .d_msb            (d_msb),
        .ibit_last        (ibit_last),
        .wbit_last        (wbit_last),
        .job_last         (job_last),
        .mul_mode         (rd_mul_mode),
        .w_signed         (rd_w_signed),
        .d_signed         (rd_d_signed),
        .job_scaler_b     (job_scaler_b),
        .job_quant_msbidx (job_quant_msbidx),
        .job_oprecision   (job_oprecision)
    );

    mvu_execute i_execute (
        .intf         (intf),
        .rst_n        (rst_n),
        .wmem_wr_en   (wmem_wr_en),
        .wmem_wr_addr (wmem_wr_addr),
        .wmem_wr_word (wmem_wr_word),
        .dmem_wr_en   (dmem_wr_en),
        .dmem_wr_addr (dmem_wr_addr),
        .dmem_wr_word (dmem_wr_word),
        .rd_en        (rd_en),
        .waddr        (waddr),
        .daddr        (daddr),
        .w_msb        (w_msb),
        .d_msb        (d_msb),
        .ibit_last    (ibit_last),
        .wbit_last    (wbit_last),
        .job_last     (job_last),
        .mul_mode     (rd_mul_mode),
        .w_signed     (rd_w_signed),
        .d_signed     (rd_d_signed),
        .sum_ready    (sum_ready),
        .sum_valid    (sum_valid),
        .sum          (sum),
        .exec_hold    (exec_hold)
    );

    mvu_result i_result (
        .intf             (intf),
        .rst_n            (rst_n),
        .sum_valid        (sum_valid),
        .sum_ready        (sum_ready),
        .sum              (sum),
        .job_scaler_b     (job_scaler_b),
        .job_quant_msbidx (job_quant_msbidx),
        .job_oprecision   (job_oprecision),
        .result_valid     (result_valid),
        .result_ready     (result_ready),
        .result           (result)
    );

endmodule

`default_nettype wire
